/* design/segway_pkg.sv */
package segway_pkg;

  ////////////////////////////////////////////////////////////
  // fixed-point types
  ////////////////////////////////////////////////////////////
  typedef logic signed [11:0] duty_t;   // forward minus reverse high time
  typedef logic signed [15:0] fix16_t;  // lean, torque, rate, angle, sensor words

  // spi transaction phases
  typedef enum logic [1:0] {
    IDLE,   // waiting for slave select and first sclk fall
    HALF1,  // command byte coming in
    HALF2   // response byte going out
  } spi_state_e;

  // inertial sensor read addresses that the model answers
  typedef enum logic [6:0] {
    PTCH_L = 7'h22,
    PTCH_H = 7'h23,
    AZ_L   = 7'h2C,
    AZ_H   = 7'h2D
  } sensor_addr_e;

  ////////////////////////////////////////////////////////////
  // pwm capture
  ////////////////////////////////////////////////////////////
  localparam int PWM_CNT_W    = 11;     // high-time counter width
  localparam int DUTY_TIMEOUT = 2048;   // no rise for this long means zero duty
  localparam int DUTY_TMR_W   = $clog2(DUTY_TIMEOUT) + 1;

  ////////////////////////////////////////////////////////////
  // physics
  ////////////////////////////////////////////////////////////
  localparam int          CALC_TIMEOUT = 2048;  // forced step when pwm is idle
  localparam int          CALC_TMR_W   = $clog2(CALC_TIMEOUT) + 1;
  localparam logic [11:0] MIN_DUTY     = 12'h38E;  // edge of the low-torque dead zone
  localparam int          TORQUE_GAIN  = 14;       // slope above the dead zone

  // sensor model offsets and scaling
  localparam fix16_t AZ_OFFSET      = 16'h00A0;
  localparam fix16_t PTCH_RT_OFFSET = 16'h0050;
  localparam int     PTCH_RT_GAIN   = -12;       // applied before the >>>4

  ////////////////////////////////////////////////////////////
  // sensor interface
  ////////////////////////////////////////////////////////////
  localparam int         ODR_CYCLES        = 2048;   // clk cycles per int period
  localparam int         ODR_W             = $clog2(ODR_CYCLES);
  localparam logic [7:0] WRITE_RESPONSE    = 8'hA5;
  localparam logic [7:0] UNMAPPED_RESPONSE = 8'h00;

endpackage

/* design/sensor_spi_if.sv */
interface sensor_spi_if;

  // fsm -> shifter
  logic       init;       // clears bit count and tx at transaction start
  logic       ld_tx;      // parallel load of the response byte
  logic [7:0] tx_byte;    // response chosen from the command byte

  // shifter -> fsm
  logic       ss_active;  // synchronized select, high while addressed
  logic       sclk_fall;  // single clk pulse per sclk falling edge
  logic [3:0] bit_cnt;    // sclk falls counted since init
  logic [7:0] rx_byte;    // most recent 8 mosi bits

  modport fsm (
    output init, ld_tx, tx_byte,
    input  ss_active, sclk_fall, bit_cnt, rx_byte
  );

  modport shifter (
    input  init, ld_tx, tx_byte,
    output ss_active, sclk_fall, bit_cnt, rx_byte
  );

endinterface

/* design/pwm_duty_meter.sv */
module pwm_duty_meter import segway_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  pwm_frwrd,  // forward drive line
  input  logic  pwm_rev,    // reverse drive line
  output logic  pwm_any,    // registered level, either line high
  output duty_t duty        // signed net duty of this wheel
);

  logic                  frwrd_ff;
  logic                  rev_ff;
  logic                  pwm_rise;
  logic                  pwm_fall;
  logic [PWM_CNT_W-1:0]  frwrd_cnt;
  logic [PWM_CNT_W-1:0]  rev_cnt;
  logic [DUTY_TMR_W-1:0] rise_tmr;   // cycles since the last rise
  logic                  rise_tmo;

  ////////////////////////////////////////////////////////////
  // edge detection
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      frwrd_ff <= 1'b0;
      rev_ff   <= 1'b0;
    end else begin
      frwrd_ff <= pwm_frwrd;
      rev_ff   <= pwm_rev;
    end
  end

  assign pwm_rise = (pwm_frwrd & ~frwrd_ff) | (pwm_rev & ~rev_ff);
  assign pwm_fall = (~pwm_frwrd & frwrd_ff) | (~pwm_rev & rev_ff);
  assign pwm_any  = frwrd_ff | rev_ff;

  // high-time counters, both restart on any rise
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      frwrd_cnt <= '0;
      rev_cnt   <= '0;
    end else if (pwm_rise) begin
      frwrd_cnt <= PWM_CNT_W'(1);
      rev_cnt   <= PWM_CNT_W'(1);
    end else begin
      if (pwm_frwrd)
        frwrd_cnt <= frwrd_cnt + 1'b1;
      if (pwm_rev)
        rev_cnt <= rev_cnt + 1'b1;
    end
  end

  // zero-duty detect, saturates at the timeout
  assign rise_tmo = (rise_tmr == DUTY_TMR_W'(DUTY_TIMEOUT));

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      rise_tmr <= '0;
    else if (pwm_rise)
      rise_tmr <= '0;
    else if (!rise_tmo)
      rise_tmr <= rise_tmr + 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      duty <= '0;
    else if (rise_tmo)
      duty <= '0;                                      // lines went quiet
    else if (pwm_fall)
      duty <= duty_t'({1'b0, frwrd_cnt}) - duty_t'({1'b0, rev_cnt});
  end

  // an h-bridge never drives both directions at once
  pwm_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(pwm_frwrd && pwm_rev));

endmodule

/* design/platform_physics.sv */
module platform_physics import segway_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  fix16_t rider_lean,    // forward lean torque of the rider
  input  duty_t  duty_lft,
  input  duty_t  duty_rght,
  input  logic   pwm_any_lft,
  input  logic   pwm_any_rght,
  output fix16_t az,            // vertical accel word of the sensor
  output fix16_t ptch_rate      // pitch-rate word of the sensor
);

  logic                  any_pwm;
  logic                  any_pwm_ff;
  logic                  last_fall;     // all four lines just went low
  logic                  calc_physics;  // one-cycle step strobe
  logic [CALC_TMR_W-1:0] calc_tmr;
  logic                  calc_tmo;

  fix16_t              rate;          // platform angular rate
  fix16_t              angle;         // platform angle
  fix16_t              torque_lft;
  fix16_t              torque_rght;
  fix16_t              net_torque;
  fix16_t              friction;
  fix16_t              rate_nxt;
  fix16_t              angle_nxt;
  logic [15:0]         rate_mag;
  logic signed [31:0]  ptch_prod;

  // motor torque from duty is steep above the dead zone
  function automatic fix16_t torque(input duty_t d);
    logic [11:0] duty_abs;
    logic [15:0] torque_abs;
    duty_abs = d[11] ? -d : d;
    if (duty_abs > MIN_DUTY)
      torque_abs = 16'(TORQUE_GAIN * (duty_abs - MIN_DUTY) + MIN_DUTY);
    else
      torque_abs = {4'h0, duty_abs};
    torque = d[11] ? -fix16_t'({1'b0, torque_abs[15:1]}) : fix16_t'({1'b0, torque_abs[15:1]});
  endfunction

  ////////////////////////////////////////////////////////////
  // step trigger
  ////////////////////////////////////////////////////////////
  assign any_pwm   = pwm_any_lft | pwm_any_rght;
  assign last_fall = ~any_pwm & any_pwm_ff;
  assign calc_tmo  = (calc_tmr == CALC_TMR_W'(CALC_TIMEOUT));

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      any_pwm_ff   <= 1'b0;
      calc_physics <= 1'b0;
    end else begin
      any_pwm_ff   <= any_pwm;
      calc_physics <= calc_tmo | last_fall;   // timeout keeps the model alive
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      calc_tmr <= '0;
    else if (calc_physics || calc_tmo)
      calc_tmr <= '0;
    else
      calc_tmr <= calc_tmr + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // one integration step
  ////////////////////////////////////////////////////////////
  assign torque_lft  = torque(duty_lft);
  assign torque_rght = torque(duty_rght);
  assign net_torque  = rider_lean - torque_lft - torque_rght;

  // friction opposes the present rate
  assign rate_mag = rate[15] ? -rate : rate;

  always_comb begin
    if (rate_mag > 16'h0400)
      friction = rate >>> 10;          // viscous above the knee
    else if (rate[15])
      friction = -16'sd1;
    else if (rate != 16'sd0)
      friction = 16'sd1;
    else
      friction = 16'sd0;
  end

  assign rate_nxt  = rate + (net_torque >>> 3) - friction;
  assign angle_nxt = angle + (rate_nxt >>> 6);
  assign ptch_prod = rate_nxt * PTCH_RT_GAIN;     // sensor scaling of the rate

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rate      <= '0;
      angle     <= '0;
      az        <= AZ_OFFSET;
      ptch_rate <= PTCH_RT_OFFSET;
    end else if (calc_physics) begin
      rate      <= rate_nxt;
      angle     <= angle_nxt;
      az        <= (angle_nxt >>> 3) + AZ_OFFSET;
      ptch_rate <= fix16_t'(ptch_prod[19:4]) + PTCH_RT_OFFSET;
    end
  end

endmodule

/* design/spi_shifter.sv */
module spi_shifter (
  input  logic clk,
  input  logic rst_n,
  input  logic ss_n,        // raw select from the master
  input  logic sclk,        // raw serial clock, idles high
  input  logic mosi,
  output logic miso,        // floats while deselected
  sensor_spi_if.shifter spi
);

  logic        sclk_ff1;
  logic        sclk_ff2;
  logic        sclk_ff3;    // edge detect stage
  logic        ss_n_ff1;
  logic        ss_n_ff2;
  logic        mosi_ff1;
  logic        mosi_ff2;
  logic        sclk_rise;
  logic [7:0]  rx_shft;
  logic [15:0] tx_shft;
  logic [3:0]  bit_cnt;

  ////////////////////////////////////////////////////////////
  // pin synchronizers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      sclk_ff1 <= 1'b1;     // sclk and ss_n idle high
      sclk_ff2 <= 1'b1;
      sclk_ff3 <= 1'b1;
      ss_n_ff1 <= 1'b1;
      ss_n_ff2 <= 1'b1;
    end else begin
      sclk_ff1 <= sclk;
      sclk_ff2 <= sclk_ff1;
      sclk_ff3 <= sclk_ff2;
      ss_n_ff1 <= ss_n;
      ss_n_ff2 <= ss_n_ff1;
    end
  end

  always_ff @(posedge clk) begin
    mosi_ff1 <= mosi;
    mosi_ff2 <= mosi_ff1;   // same depth as sclk_ff2
  end

  assign sclk_rise     = sclk_ff2 & ~sclk_ff3;
  assign spi.sclk_fall = ~sclk_ff2 & sclk_ff3;
  assign spi.ss_active = ~ss_n_ff2;

  ////////////////////////////////////////////////////////////
  // shift registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (sclk_rise && spi.ss_active)
      rx_shft <= {rx_shft[6:0], mosi_ff2};   // msb first
  end

  always_ff @(posedge clk) begin
    if (spi.init)
      tx_shft <= '0;
    else if (spi.ld_tx)
      tx_shft <= {spi.tx_byte, 8'h00};
    else if (spi.sclk_fall)
      tx_shft <= {tx_shft[14:0], 1'b0};
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (spi.init)
      bit_cnt <= '0;
    else if (spi.sclk_fall)
      bit_cnt <= bit_cnt + 1'b1;
  end

  assign spi.rx_byte = rx_shft;
  assign spi.bit_cnt = bit_cnt;
  assign miso        = ss_n ? 1'bz : tx_shft[15];

endmodule

/* design/spi_txn_fsm.sv */
module spi_txn_fsm import segway_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  fix16_t az,
  input  fix16_t ptch_rate,
  output logic   clr_int,     // pulse when the pitch-rate low byte is read
  sensor_spi_if.fsm spi
);

  spi_state_e   state;
  spi_state_e   nxt_state;
  sensor_addr_e addr;
  logic         cmd_done;     // eighth bit in and the next fall carries the response
  logic [7:0]   resp;

  assign addr     = sensor_addr_e'(spi.rx_byte[6:0]);
  assign cmd_done = (state == HALF1) && spi.ss_active && spi.sclk_fall &&
                    (spi.bit_cnt == 4'd7);

  ////////////////////////////////////////////////////////////
  // response byte
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (!spi.rx_byte[7]) begin
      resp = WRITE_RESPONSE;          // writes are acknowledged only
    end else begin
      case (addr)
        PTCH_L:  resp = ptch_rate[7:0];
        PTCH_H:  resp = ptch_rate[15:8];
        AZ_L:    resp = az[7:0];
        AZ_H:    resp = az[15:8];
        default: resp = UNMAPPED_RESPONSE;
      endcase
    end
  end

  assign spi.tx_byte = resp;
  assign clr_int     = cmd_done && spi.rx_byte[7] && (addr == PTCH_L);

  ////////////////////////////////////////////////////////////
  // transaction state machine
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;
    spi.init  = 1'b0;
    spi.ld_tx = 1'b0;
    case (state)
      IDLE: begin
        if (spi.ss_active && spi.sclk_fall) begin   // first fall opens the frame
          spi.init  = 1'b1;
          nxt_state = HALF1;
        end
      end
      HALF1: begin
        if (!spi.ss_active) begin
          nxt_state = IDLE;                          // aborted by the master
        end else if (cmd_done) begin
          spi.ld_tx = 1'b1;
          nxt_state = HALF2;
        end
      end
      HALF2: begin
        if (!spi.ss_active || (spi.sclk_fall && spi.bit_cnt == 4'd14))
          nxt_state = IDLE;
      end
      default: nxt_state = IDLE;
    endcase
  end

  // the shifter counts the same fall that loads the response
  ld_tx_on_bit8: assert property (@(posedge clk) disable iff (!rst_n)
    spi.ld_tx |=> (spi.bit_cnt == 4'd8));

endmodule

/* design/odr_timer.sv */
module odr_timer import segway_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic clr_int,     // from a pitch-rate read
  output logic int_req      // data ready, active high
);

  logic [ODR_W-1:0] odr_cnt;
  logic             odr_wrap;   // one sample period elapsed

  assign odr_wrap = (odr_cnt == ODR_W'(ODR_CYCLES - 1));

  // free running from reset
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      odr_cnt <= '0;
    else if (odr_wrap)
      odr_cnt <= '0;
    else
      odr_cnt <= odr_cnt + 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      int_req <= 1'b0;
    else if (clr_int)
      int_req <= 1'b0;            // clear wins over a same-cycle wrap
    else if (odr_wrap)
      int_req <= 1'b1;
  end

  // a pitch read clears once and is never a held level
  clr_int_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    clr_int |=> !clr_int);

endmodule

/* design/segway_model.sv */
module segway_model import segway_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   ss_n,        // sensor slave select
  input  logic   sclk,
  input  logic   mosi,
  input  logic   pwm1_lft,    // left forward
  input  logic   pwm2_lft,    // left reverse
  input  logic   pwm1_rght,   // right forward
  input  logic   pwm2_rght,   // right reverse
  input  fix16_t rider_lean,
  output logic   miso,
  output logic   int_req
);

  duty_t  duty_lft;
  duty_t  duty_rght;
  logic   pwm_any_lft;
  logic   pwm_any_rght;
  fix16_t az;
  fix16_t ptch_rate;
  logic   clr_int;

  sensor_spi_if spi ();

  ////////////////////////////////////////////////////////////
  // motor drive capture and platform physics
  ////////////////////////////////////////////////////////////
  pwm_duty_meter u_lft_meter (
    .clk       (clk),
    .rst_n     (rst_n),
    .pwm_frwrd (pwm1_lft),
    .pwm_rev   (pwm2_lft),
    .pwm_any   (pwm_any_lft),
    .duty      (duty_lft)
  );

  pwm_duty_meter u_rght_meter (
    .clk       (clk),
    .rst_n     (rst_n),
    .pwm_frwrd (pwm1_rght),
    .pwm_rev   (pwm2_rght),
    .pwm_any   (pwm_any_rght),
    .duty      (duty_rght)
  );

  platform_physics u_physics (
    .clk          (clk),
    .rst_n        (rst_n),
    .rider_lean   (rider_lean),
    .duty_lft     (duty_lft),
    .duty_rght    (duty_rght),
    .pwm_any_lft  (pwm_any_lft),
    .pwm_any_rght (pwm_any_rght),
    .az           (az),
    .ptch_rate    (ptch_rate)
  );

  ////////////////////////////////////////////////////////////
  // inertial sensor model
  ////////////////////////////////////////////////////////////
  spi_shifter u_shifter (
    .clk   (clk),
    .rst_n (rst_n),
    .ss_n  (ss_n),
    .sclk  (sclk),
    .mosi  (mosi),
    .miso  (miso),
    .spi   (spi.shifter)
  );

  spi_txn_fsm u_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .az        (az),
    .ptch_rate (ptch_rate),
    .clr_int   (clr_int),
    .spi       (spi.fsm)
  );

  odr_timer u_odr (
    .clk     (clk),
    .rst_n   (rst_n),
    .clr_int (clr_int),
    .int_req (int_req)
  );

endmodule

/* bench/segway_model_tb.sv */
module segway_model_tb import segway_pkg::*; ();

  ////////////////////////////////////////////////////////////
  // run lengths, in clk cycles
  ////////////////////////////////////////////////////////////
  localparam int SCLK_HALF     = 8;                  // clk cycles per sclk half period
  localparam int XFER_CYCLES   = 34 * SCLK_HALF;     // select, 16 bits, deselect
  localparam int RESET_CYCLES  = 3;
  localparam int PWM_MIN       = int'(MIN_DUTY) + 40; // safely past the dead zone
  localparam int PWM_MAX       = 1100;
  localparam int PWM_GAP       = 200;                // low time between pulses
  localparam int DRIVE_PERIODS = 5;

  localparam int REST_CYCLES   = RESET_CYCLES + 6 * XFER_CYCLES + 2;
  localparam int INT_CYCLES    = RESET_CYCLES + ODR_CYCLES + 4 + 2 * XFER_CYCLES;
  localparam int LEAN_CYCLES   = RESET_CYCLES + CALC_TIMEOUT + 3 + 4 * XFER_CYCLES;
  localparam int DRIVE_CYCLES  = RESET_CYCLES + DRIVE_PERIODS * (PWM_MAX + PWM_GAP) +
                                 4 * XFER_CYCLES;
  localparam int TOTAL_CYCLES  = REST_CYCLES + INT_CYCLES + LEAN_CYCLES + 2 * DRIVE_CYCLES;
  localparam longint WATCHDOG_TIME = longint'(TOTAL_CYCLES) * 10 * 2;

  logic   clk;
  logic   rst_n;
  logic   ss_n;
  logic   sclk;
  logic   mosi;
  logic   pwm1_lft;
  logic   pwm2_lft;
  logic   pwm1_rght;
  logic   pwm2_rght;
  fix16_t rider_lean;
  wire    miso;           // floats while deselected
  logic   int_req;
  string  test_name;

  segway_model u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .ss_n       (ss_n),
    .sclk       (sclk),
    .mosi       (mosi),
    .pwm1_lft   (pwm1_lft),
    .pwm2_lft   (pwm2_lft),
    .pwm1_rght  (pwm1_rght),
    .pwm2_rght  (pwm2_rght),
    .rider_lean (rider_lean),
    .miso       (miso),
    .int_req    (int_req)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_fix16(input string what, input fix16_t exp, input fix16_t act);
    if (act !== exp)
      abort_run($sformatf("Error %s %s: expected 0x%h, actual 0x%h", test_name, what, exp, act));
  endtask

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
      abort_run($sformatf("Error %s %s: expected 0x%h, actual 0x%h", test_name, what, exp, act));
  endtask

  task automatic check_level(input string what, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("Error %s %s: expected %b, actual %b", test_name, what, exp, act));
  endtask

  // sign of a sensor word against its rest offset
  task automatic check_trend(input string what, input fix16_t bound, input fix16_t act,
                             input logic above);
    logic ok;
    ok = above ? (act > bound) : (act < bound);
    if (ok !== 1'b1)
      abort_run($sformatf("Error %s %s: expected %s 0x%h, actual 0x%h", test_name, what,
                          above ? "above" : "below", bound, act));
  endtask

  ////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////
  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;                 // inputs change just after the edge
    end
  endtask

  task automatic reset_dut(input fix16_t lean);
    rst_n      = 1'b0;
    ss_n       = 1'b1;
    sclk       = 1'b1;    // sclk idles high
    mosi       = 1'b0;
    pwm1_lft   = 1'b0;
    pwm2_lft   = 1'b0;
    pwm1_rght  = 1'b0;
    pwm2_rght  = 1'b0;
    rider_lean = lean;
    wait_cycles(RESET_CYCLES);
    rst_n = 1'b1;
  endtask

  // one 16 bit frame, mosi moves on sclk fall, miso taken just before the rise
  task automatic spi_xfer(input logic [7:0] cmd, input logic [7:0] wdata,
                          output logic [7:0] rdata);
    logic [15:0] frame;
    int          i;
    frame = {cmd, wdata};
    rdata = 8'h00;
    ss_n  = 1'b0;
    wait_cycles(SCLK_HALF);
    for (i = 15; i >= 0; i--) begin
      sclk = 1'b0;
      mosi = frame[i];
      wait_cycles(SCLK_HALF);
      if (i < 8)
        rdata[i] = miso;  // response byte, msb first
      sclk = 1'b1;
      wait_cycles(SCLK_HALF);
    end
    ss_n = 1'b1;
    wait_cycles(SCLK_HALF);
  endtask

  task automatic read_word(input sensor_addr_e lo_addr, input sensor_addr_e hi_addr,
                           output fix16_t word);
    logic [7:0] lo_byte;
    logic [7:0] hi_byte;
    spi_xfer({1'b1, lo_addr}, 8'h00, lo_byte);
    spi_xfer({1'b1, hi_addr}, 8'h00, hi_byte);
    word = {hi_byte, lo_byte};
  endtask

  // equal pulses on both wheels, pwm1 forward or pwm2 reverse
  task automatic drive_pulses(input logic reverse);
    int width;
    int p;
    for (p = 0; p < DRIVE_PERIODS; p++) begin
      width     = PWM_MIN + int'($urandom % (PWM_MAX - PWM_MIN));
      pwm1_lft  = !reverse;
      pwm1_rght = !reverse;
      pwm2_lft  = reverse;
      pwm2_rght = reverse;
      wait_cycles(width);
      pwm1_lft  = 1'b0;   // common fall gives one physics step
      pwm1_rght = 1'b0;
      pwm2_lft  = 1'b0;
      pwm2_rght = 1'b0;
      wait_cycles(PWM_GAP);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic rest_values();
    fix16_t     word;
    logic [7:0] resp;
    test_name = "rest_values";
    reset_dut(16'sd0);
    check_level("miso idle", 1'bz, miso);
    read_word(PTCH_L, PTCH_H, word);
    check_fix16("ptch_rate", PTCH_RT_OFFSET, word);
    read_word(AZ_L, AZ_H, word);
    check_fix16("az", AZ_OFFSET, word);
    spi_xfer({1'b0, 7'h10}, 8'h3C, resp);           // write, data is dropped
    check_byte("write response", WRITE_RESPONSE, resp);
    spi_xfer({1'b1, 7'h0F}, 8'h00, resp);           // nothing mapped here
    check_byte("unmapped read", UNMAPPED_RESPONSE, resp);
    check_level("miso after frames", 1'bz, miso);
  endtask

  task automatic int_flag();
    int         cycles;
    logic [7:0] resp;
    test_name = "int_flag";
    reset_dut(16'sd0);
    check_level("int after reset", 1'b0, int_req);
    cycles = 0;
    while (int_req !== 1'b1) begin
      wait_cycles(1);
      cycles++;
      if (cycles > ODR_CYCLES + 4)
        abort_run("int_req did not rise within one output data period");
    end
    spi_xfer({1'b1, AZ_L}, 8'h00, resp);
    check_level("int after az read", 1'b1, int_req);   // only pitch rate clears
    spi_xfer({1'b1, PTCH_L}, 8'h00, resp);
    check_level("int after ptch read", 1'b0, int_req);
  endtask

  task automatic first_lean_step();
    fix16_t             lean;
    fix16_t             rate_exp;
    fix16_t             angle_exp;
    logic signed [31:0] prod;
    fix16_t             word;
    test_name = "first_lean_step";
    lean      = 16'sh5A30;
    // one step from rest, no torque and no friction
    rate_exp  = lean >>> 3;
    angle_exp = rate_exp >>> 6;
    prod      = rate_exp * PTCH_RT_GAIN;
    reset_dut(lean);
    wait_cycles(CALC_TIMEOUT + 3);                  // forced step has landed
    read_word(PTCH_L, PTCH_H, word);
    check_fix16("ptch_rate", fix16_t'(prod >>> 4) + PTCH_RT_OFFSET, word);
    read_word(AZ_L, AZ_H, word);
    check_fix16("az", (angle_exp >>> 3) + AZ_OFFSET, word);
  endtask

  task automatic wheel_drive(input logic reverse);
    fix16_t word;
    test_name = reverse ? "reverse_drive" : "forward_drive";
    reset_dut(16'sd0);
    drive_pulses(reverse);
    // forward torque tips the platform back, reverse the other way
    read_word(PTCH_L, PTCH_H, word);
    check_trend("ptch_rate", PTCH_RT_OFFSET, word, !reverse);
    read_word(AZ_L, AZ_H, word);
    check_trend("az", AZ_OFFSET, word, reverse);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////
  initial begin
    int unsigned seed_draw;
    clk        = 1'b0;
    rst_n      = 1'b0;
    ss_n       = 1'b1;
    sclk       = 1'b1;
    mosi       = 1'b0;
    pwm1_lft   = 1'b0;
    pwm2_lft   = 1'b0;
    pwm1_rght  = 1'b0;
    pwm2_rght  = 1'b0;
    rider_lean = 16'sd0;
    test_name  = "";
    seed_draw  = $urandom(32'h4a73);                // seeds the generator
    rest_values();
    int_flag();
    first_lean_step();
    wheel_drive(1'b0);
    wheel_drive(1'b1);
    $display("Test passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    abort_run($sformatf("Timeout: run did not finish in %0d time units", WATCHDOG_TIME));
  end

endmodule

/* segway_model.f */
design/segway_pkg.sv
design/sensor_spi_if.sv
design/pwm_duty_meter.sv
design/platform_physics.sv
design/spi_shifter.sv
design/spi_txn_fsm.sv
design/odr_timer.sv
design/segway_model.sv
bench/segway_model_tb.sv
